/* design/mips_settings.svh */
`ifndef MIPS_SETTINGS_SVH
`define MIPS_SETTINGS_SVH

// data RAM byte window and word index width.
`define DM_BASE       32'h0000_0000
`define DM_LAST       32'h0000_2fff
`define DM_ADDR_BITS  14

// peripheral registers, one word each.
`define IO_SCRATCH    32'h0000_7f00
`define IO_CTRL       32'h0000_7f04
`define IO_WCOUNT     32'h0000_7f08

`define EXC_ADEL      5'd4
`define EXC_ADES      5'd5

// primary opcodes, bits 31:26 of the instruction.
`define OP_LB         6'h20
`define OP_LH         6'h21
`define OP_LW         6'h23
`define OP_LBU        6'h24
`define OP_LHU        6'h25
`define OP_SB         6'h28
`define OP_SH         6'h29
`define OP_SW         6'h2b
`define OP_COP0       6'h10

// rs field of a coprocessor 0 instruction.
`define RS_MF         5'h00
`define RS_MT         5'h04

`endif

/* design/mips_pkg.sv */
package mips_pkg;

    // width and signedness of one access.
    typedef enum logic [2:0] {
        none   = 3'd0,
        byte_s = 3'd1,
        byte_u = 3'd2,
        half_s = 3'd3,
        half_u = 3'd4,
        word   = 3'd5
    } access_size_e;

    typedef struct packed {
        logic [31:0] inst;
        logic [31:0] ao;         // alu result, the access address.
        logic [31:0] rt;
        logic        exception;
        logic [31:0] epc;
        logic [4:0]  exc_code;
        logic        bd;
    } ex_mem_t;

    typedef struct packed {
        logic [31:0]  address;
        logic [31:0]  wdata;
        access_size_e read_size;
        access_size_e write_size;
    } mem_req_t;

    typedef struct packed {
        logic [31:0] inst;
        logic [31:0] ao;
        logic [31:0] mo;         // loaded data, already extended.
        logic        exception;
        logic [31:0] epc;
        logic [4:0]  exc_code;
        logic        bd;
    } mem_wb_t;

    // one committed RAM write, reported a cycle after the edge.
    typedef struct packed {
        logic        enable;
        logic [31:0] address;
        logic [31:0] data;
    } dbg_t;

endpackage

/* design/mem_ctrl.sv */
`timescale 1ns/10ps
`include "mips_settings.svh"

module mem_ctrl import mips_pkg::*; (
    input  logic [31:0]  inst,
    output access_size_e read_size,
    output access_size_e write_size,
    output logic         load,
    output logic         store,
    output logic         move_from,
    output logic         move_to
);

    logic [5:0] opcode;
    logic [4:0] rs;

    assign opcode = inst[31:26];
    assign rs     = inst[25:21];

    // loads pick the extension, stores only care about the width.
    always_comb begin
        read_size  = none;
        write_size = none;
        case (opcode)
            `OP_LB: begin
                read_size = byte_s;
            end
            `OP_LBU: begin
                read_size = byte_u;
            end
            `OP_LH: begin
                read_size = half_s;
            end
            `OP_LHU: begin
                read_size = half_u;
            end
            `OP_LW: begin
                read_size = word;
            end
            `OP_SB: begin
                write_size = byte_u;
            end
            `OP_SH: begin
                write_size = half_u;
            end
            `OP_SW: begin
                write_size = word;
            end
            default: begin
                read_size  = none;
                write_size = none;
            end
        endcase
    end

    assign load      = (read_size != none);
    assign store     = (write_size != none);
    assign move_from = (opcode == `OP_COP0) && (rs == `RS_MF);
    assign move_to   = (opcode == `OP_COP0) && (rs == `RS_MT);

endmodule

/* design/data_mem.sv */
`timescale 1ns/10ps
`include "mips_settings.svh"

module data_mem import mips_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  mem_req_t    req,
    input  logic        commit,
    output logic        accepted,
    output logic [31:0] rdata,
    output dbg_t        dbg
);

    logic [31:0] mem [0:(1 << `DM_ADDR_BITS) - 1];

    logic [`DM_ADDR_BITS-1:0] idx;
    logic [31:0] rd_word;
    logic [31:0] shifted;
    logic [31:0] lane_data;
    logic [31:0] merged;
    logic [3:0]  lane_mask;
    logic        do_write;

    assign accepted = (req.address >= `DM_BASE) && (req.address <= `DM_LAST);
    assign idx      = req.address[`DM_ADDR_BITS+1:2];
    assign rd_word  = mem[idx];

    // little endian lanes, the low address bits pick the byte.
    assign shifted = rd_word >> {req.address[1:0], 3'b000};

    always_comb begin
        case (req.read_size)
            byte_s:  rdata = {{24{shifted[7]}}, shifted[7:0]};
            byte_u:  rdata = {24'h0, shifted[7:0]};
            half_s:  rdata = {{16{shifted[15]}}, shifted[15:0]};
            half_u:  rdata = {16'h0, shifted[15:0]};
            default: rdata = rd_word;
        endcase
    end

    always_comb begin
        case (req.write_size)
            byte_s, byte_u: lane_mask = 4'b0001 << req.address[1:0];
            half_s, half_u: lane_mask = 4'b0011 << req.address[1:0];
            word:           lane_mask = 4'b1111;
            default:        lane_mask = 4'b0000;
        endcase
    end

    assign lane_data = req.wdata << {req.address[1:0], 3'b000};

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            merged[8*i +: 8] = lane_mask[i] ? lane_data[8*i +: 8] : rd_word[8*i +: 8];
        end
    end

    assign do_write = commit && accepted && (lane_mask != 4'b0000);

    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[idx] <= merged;
        end
    end

    // the strobe carries the whole word as it reads after the write.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dbg <= '0;
        end else begin
            dbg.enable  <= do_write;
            dbg.address <= {req.address[31:2], 2'b00};
            dbg.data    <= merged;
        end
    end

endmodule

/* design/io_bridge.sv */
`timescale 1ns/10ps
`include "mips_settings.svh"

module io_bridge import mips_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  mem_req_t    req,
    input  logic        commit,
    output logic        accepted,
    output logic [31:0] rdata
);

    logic [31:0] scratch;
    logic [31:0] ctrl;
    logic [31:0] wcount;

    logic hit_scratch;
    logic hit_ctrl;
    logic hit_wcount;
    logic do_write;

    assign hit_scratch = (req.address == `IO_SCRATCH);
    assign hit_ctrl    = (req.address == `IO_CTRL);
    assign hit_wcount  = (req.address == `IO_WCOUNT);

    // word accesses only. The counter is read only.
    always_comb begin
        accepted = 1'b0;
        if (req.read_size == word) begin
            accepted = hit_scratch || hit_ctrl || hit_wcount;
        end else if (req.write_size == word) begin
            accepted = hit_scratch || hit_ctrl;
        end
    end

    always_comb begin
        case (1'b1)
            hit_scratch: rdata = scratch;
            hit_ctrl:    rdata = ctrl;
            hit_wcount:  rdata = wcount;
            default:     rdata = 32'h0;
        endcase
    end

    assign do_write = commit && accepted;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            scratch <= 32'h0;
            ctrl    <= 32'h0;
            wcount  <= 32'h0;
        end else if (do_write) begin
            if (hit_scratch) begin
                scratch <= req.wdata;
            end
            if (hit_ctrl) begin
                ctrl <= req.wdata;
            end
            wcount <= wcount + 32'd1;    // counts every committed bridge write.
        end
    end

endmodule

/* design/mem_stage.sv */
`timescale 1ns/10ps
`include "mips_settings.svh"

module mem_stage import mips_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    valid,
    input  ex_mem_t ex,
    output mem_wb_t wb,
    output dbg_t    dbg
);

    access_size_e read_size;
    access_size_e write_size;
    access_size_e size;
    mem_req_t     req;
    logic         load;
    logic         store;
    logic         move_from;
    logic         move_to;
    logic         aligned;
    logic         commit;
    logic         dm_accepted;
    logic         io_accepted;
    logic [31:0]  dm_rdata;
    logic [31:0]  io_rdata;
    logic         new_exc;

    mem_ctrl u_ctrl (
        .inst       (ex.inst),
        .read_size  (read_size),
        .write_size (write_size),
        .load       (load),
        .store      (store),
        .move_from  (move_from),
        .move_to    (move_to)
    );

    assign req.address    = ex.ao;
    assign req.wdata      = ex.rt;
    assign req.read_size  = read_size;
    assign req.write_size = write_size;

    assign size = load ? read_size : write_size;

    always_comb begin
        case (size)
            half_s, half_u: aligned = (ex.ao[0] == 1'b0);
            word:           aligned = (ex.ao[1:0] == 2'b00);
            default:        aligned = 1'b1;
        endcase
    end

    // each target still gates the write with its own accept.
    assign commit = valid && store && !ex.exception && aligned;

    data_mem u_dm (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (req),
        .commit   (commit),
        .accepted (dm_accepted),
        .rdata    (dm_rdata),
        .dbg      (dbg)
    );

    io_bridge u_io (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (req),
        .commit   (commit),
        .accepted (io_accepted),
        .rdata    (io_rdata)
    );

    assign new_exc = (load || store) && (!aligned || !(dm_accepted || io_accepted));

    assign wb.inst      = ex.inst;
    assign wb.ao        = (move_from || move_to) ? ex.rt : ex.ao;
    assign wb.mo        = dm_accepted ? dm_rdata : (io_accepted ? io_rdata : 32'h0);
    assign wb.exception = ex.exception || new_exc;
    assign wb.exc_code  = ex.exception ? ex.exc_code : (load ? `EXC_ADEL : `EXC_ADES);
    assign wb.epc       = ex.epc;
    assign wb.bd        = ex.bd;

endmodule

/* design/mem_subsys_top.sv */
`timescale 1ns/10ps

module mem_subsys_top import mips_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    in_valid,
    input  ex_mem_t in_data,
    output logic    out_valid,
    output mem_wb_t out_data,
    output dbg_t    dbg
);

    ex_mem_t ex_q;
    logic    ex_valid;
    mem_wb_t wb;

    // ex/mem and mem/wb valid bits.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_valid  <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            ex_valid  <= in_valid;
            out_valid <= ex_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            ex_q <= in_data;
        end
        if (ex_valid) begin
            out_data <= wb;    // result of the stage one cycle after capture.
        end
    end

    mem_stage u_mem (
        .clk   (clk),
        .rst_n (rst_n),
        .valid (ex_valid),
        .ex    (ex_q),
        .wb    (wb),
        .dbg   (dbg)
    );

endmodule

/* dv/mem_model.svh */
// byte image of the data RAM and the io registers, kept in step with the items sent.
logic [7:0]  ram_img [0:12287];
logic [31:0] io_regs [0:2];    // scratch, control and write count.

// predicts the MEM/WB word of one item and applies its store to the model.
function automatic mem_wb_t predict(input ex_mem_t ex, output logic wr, output logic [31:0] word);
    logic [5:0]  op;
    int          width;
    logic        ld;
    logic        st;
    logic        in_io;
    logic        ok;
    logic [31:0] v;
    mem_wb_t     r;
    op    = ex.inst[31:26];
    ld    = op inside {`OP_LB, `OP_LBU, `OP_LH, `OP_LHU, `OP_LW};
    st    = op inside {`OP_SB, `OP_SH, `OP_SW};
    width = (op inside {`OP_LB, `OP_LBU, `OP_SB}) ? 1 :
            ((op inside {`OP_LH, `OP_LHU, `OP_SH}) ? 2 : 4);
    in_io = (width == 4) &&
            (ex.ao inside {`IO_SCRATCH, `IO_CTRL} || (ld && ex.ao == `IO_WCOUNT));
    ok    = ((ex.ao % width) == 0) && (ex.ao <= `DM_LAST || in_io);
    v     = 32'h0;
    word  = 32'h0;
    if (ok && in_io) begin
        v = io_regs[ex.ao[3:2]];
    end else if (ok) begin
        for (int i = 0; i < width; i++) begin
            v[8*i +: 8] = ram_img[ex.ao[13:0] + i];
        end
    end
    if (op == `OP_LB) v = {{24{v[7]}}, v[7:0]};
    if (op == `OP_LH) v = {{16{v[15]}}, v[15:0]};
    wr = st && ok && !ex.exception && !in_io;
    if (st && ok && !ex.exception && in_io) begin
        io_regs[ex.ao[3:2]] = ex.rt;
        io_regs[2]          = io_regs[2] + 32'd1;    // the counter sees every io write.
    end
    if (wr) begin
        for (int i = 0; i < width; i++) begin
            ram_img[ex.ao[13:0] + i] = ex.rt[8*i +: 8];
        end
        for (int i = 0; i < 4; i++) begin
            word[8*i +: 8] = ram_img[{ex.ao[13:2], 2'b00} + i];
        end
    end
    r.inst      = ex.inst;
    r.ao        = (op == `OP_COP0 && ex.inst[25:21] inside {`RS_MF, `RS_MT}) ? ex.rt : ex.ao;
    r.mo        = v;
    r.exception = ex.exception || ((ld || st) && !ok);
    r.exc_code  = ex.exception ? ex.exc_code : (ld ? `EXC_ADEL : `EXC_ADES);
    r.epc       = ex.epc;
    r.bd        = ex.bd;
    return r;
endfunction

/* dv/mem_tb.sv */
`timescale 1ns/10ps
`include "mips_settings.svh"

module mem_tb import mips_pkg::*; ();

    localparam int n_init  = 32;
    localparam int n_word  = 150;
    localparam int n_sub   = 200;
    localparam int n_fault = 150;
    localparam int n_io    = 100;
    localparam int n_cop0  = 100;
    localparam int n_total = n_init + n_word + n_sub + n_fault + n_io + n_cop0;

    localparam logic [5:0] sub_ops [0:6] = '{`OP_LB, `OP_LBU, `OP_LH, `OP_LHU,
                                             `OP_SB, `OP_SH, `OP_LW};
    localparam logic [5:0] fault_ops [0:4] = '{`OP_LH, `OP_LHU, `OP_SH, `OP_LW, `OP_SW};

    typedef struct packed {
        mem_wb_t     wb;
        logic        load;
        logic        wr;
        logic [31:0] word;
    } expect_t;

    logic    clk = 1'b0;
    logic    rst_n;
    logic    in_valid;
    ex_mem_t in_data;
    logic    out_valid;
    mem_wb_t out_data;
    dbg_t    dbg;

    logic [31:0] seed = 32'he861;
    int          cycle = 0;
    int          checks = 0;
    int          errors = 0;
    int          test_checks;
    int          test_errors;
    string       test_name = "reset";
    expect_t     exp_q [$];
    int          due_q [$];

    `include "mem_model.svh"

    mem_subsys_top dut_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_data   (in_data),
        .out_valid (out_valid),
        .out_data  (out_data),
        .dbg       (dbg)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    function automatic logic [31:0] next_random();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return {8'h0, seed[31:8]};    // the low bits of an LCG repeat too soon.
    endfunction

    function automatic logic [31:0] random_word();
        return (next_random() << 16) ^ next_random();
    endfunction

    // one of 32 RAM words spread over the whole window.
    function automatic logic [31:0] pool_addr();
        return (next_random() % 32) * 32'h180;
    endfunction

    function automatic ex_mem_t make_item(input logic [5:0] op, input logic [31:0] addr);
        ex_mem_t     ex;
        logic [31:0] r;
        r            = random_word();
        ex.inst      = {op, r[25:0]};
        ex.ao        = addr;
        ex.rt        = random_word();
        ex.exception = 1'b0;
        ex.epc       = random_word();
        ex.exc_code  = 5'd0;
        ex.bd        = r[31];
        return ex;
    endfunction

    task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("Fail %s %s: expected %h actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic send(input ex_mem_t ex);
        expect_t     e;
        logic        wr;
        logic [31:0] word;
        @(posedge clk);
        in_valid <= 1'b1;
        in_data  <= ex;
        e.wb   = predict(ex, wr, word);
        e.load = ex.inst[31:26] inside {`OP_LB, `OP_LBU, `OP_LH, `OP_LHU, `OP_LW};
        e.wr   = wr;
        e.word = word;
        exp_q.push_back(e);
        due_q.push_back(cycle + 3);    // captured at the next edge, out two edges after that.
        if (next_random() % 6 == 0) begin
            @(posedge clk);
            in_valid <= 1'b0;
        end
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_checks = checks;
        test_errors = errors;
    endtask

    task automatic finish_test();
        @(posedge clk);
        in_valid <= 1'b0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        $display("%s: %0d checks, %0d errors", test_name, checks - test_checks,
                 errors - test_errors);
    endtask

    always @(negedge clk) begin
        expect_t e;
        int      due;
        if (rst_n && dbg.enable && !out_valid) begin
            errors++;
            $display("%s: RAM write strobe seen without a result", test_name);
        end
        if (rst_n && out_valid && exp_q.size() == 0) begin
            errors++;
            $display("%s: result arrived with no item outstanding", test_name);
        end else if (rst_n && out_valid) begin
            e   = exp_q.pop_front();
            due = due_q.pop_front();
            check_value("latency", due, cycle);
            check_value("inst", e.wb.inst, out_data.inst);
            check_value("ao", e.wb.ao, out_data.ao);
            check_value("exception", e.wb.exception, out_data.exception);
            check_value("epc", e.wb.epc, out_data.epc);
            check_value("bd", e.wb.bd, out_data.bd);
            if (e.wb.exception) check_value("exc_code", e.wb.exc_code, out_data.exc_code);
            if (e.load && !e.wb.exception) check_value("mo", e.wb.mo, out_data.mo);
            check_value("dbg enable", e.wr, dbg.enable);
            if (e.wr) begin
                check_value("dbg address", {e.wb.ao[31:2], 2'b00}, dbg.address);
                check_value("dbg data", e.word, dbg.data);
            end
        end
    end

    // the budget covers every item with room for gaps and drains.
    initial begin
        repeat (n_total * 4 + 200) @(posedge clk);
        $display("watchdog expired with %0d results still outstanding", exp_q.size());
        $display("test failed");
        $finish;
    end

    initial begin
        logic [5:0]  op;
        logic [31:0] r;
        ex_mem_t     ex;
        rst_n    = 1'b0;
        in_valid = 1'b1;    // a store strobed during reset must never come out.
        in_data  = make_item(`OP_SW, 32'h0);
        foreach (io_regs[i]) io_regs[i] = 32'h0;
        repeat (16) @(posedge clk);
        rst_n    <= 1'b1;
        in_valid <= 1'b0;

        start_test("reset_and_latency");
        repeat (4) begin
            @(negedge clk);
            check_value("out_valid after reset", 0, out_valid);
            check_value("dbg enable after reset", 0, dbg.enable);
        end
        for (int i = 0; i < n_init; i++) send(make_item(`OP_SW, i * 32'h180));
        finish_test();

        start_test("word_access");
        for (int i = 0; i < n_word; i++) begin
            op = (next_random() % 2) ? `OP_SW : `OP_LW;
            send(make_item(op, pool_addr()));
        end
        finish_test();

        start_test("sub_word");
        for (int i = 0; i < n_sub; i++) begin
            op = sub_ops[next_random() % 7];
            r  = next_random() % 4;
            if (op inside {`OP_LH, `OP_LHU, `OP_SH}) begin
                r[0] = 1'b0;
            end else if (op == `OP_LW) begin
                r = 32'h0;
            end
            send(make_item(op, pool_addr() + r));
        end
        finish_test();

        start_test("address_faults");
        for (int i = 0; i < n_fault; i++) begin
            case (next_random() % 6)
                0: ex = make_item(fault_ops[next_random() % 5],
                                  pool_addr() + 1 + 2 * (next_random() % 2));
                1: ex = make_item((next_random() % 2) ? `OP_SW : `OP_LW,
                                  32'h3000 + 4 * (next_random() % 32'h1000));
                2: ex = make_item((next_random() % 2) ? `OP_SB : `OP_LH,
                                  `IO_SCRATCH + 4 * (next_random() % 3));
                3: begin
                    ex           = make_item((next_random() % 2) ? `OP_SW : `OP_LW, pool_addr());
                    r            = next_random();
                    ex.exception = 1'b1;
                    ex.exc_code  = r[4:0];
                end
                default: ex = make_item(`OP_LW, pool_addr());    // confirms memory is intact.
            endcase
            send(ex);
        end
        finish_test();

        start_test("io_registers");
        for (int i = 0; i < n_io; i++) begin
            op = (next_random() % 2) ? `OP_SW : `OP_LW;
            send(make_item(op, `IO_SCRATCH + 4 * (next_random() % 3)));
        end
        finish_test();

        start_test("cop0_moves");
        for (int i = 0; i < n_cop0; i++) begin
            r  = next_random() % 3;
            ex = make_item((r == 2) ? 6'h0d : `OP_COP0, random_word());
            if (r != 2) begin
                ex.inst[25:21] = (r == 0) ? `RS_MF : `RS_MT;
            end
            send(ex);
        end
        finish_test();

        $display("all tests: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* vlog.f */
+incdir+design
+incdir+dv
design/mips_pkg.sv
design/mem_ctrl.sv
design/data_mem.sv
design/io_bridge.sv
design/mem_stage.sv
design/mem_subsys_top.sv
dv/mem_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing -Wno-fatal --top-module mem_tb -f vlog.f -o mem_tb_sim \
    > build.log 2>&1 \
    && ./obj_dir/mem_tb_sim > sim.log 2>&1 \
    || { echo "build or run error"; cat build.log sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -qx "test passed" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
